// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    ////////////////////
    // geometry
    ////////////////////

    // one word on both the cpu and memory side
    localparam int addr_w = 32;

    // address fields, msb first
    localparam int tag_w    = 17;
    localparam int set_w    = 6;
    localparam int way_w    = 2;
    localparam int offset_w = 7;

    // set and way together pick one of 256 lines
    localparam int line_idx_w = 8;

    // 128-byte line, filled one word at a time
    localparam int words_per_line = 32;
    localparam int word_idx_w     = 5;

    ////////////////////
    // types
    ////////////////////

    // raw view for memory address arithmetic, field view for indexing
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [set_w-1:0]    set_idx;
            logic [way_w-1:0]    way_idx;
            logic [offset_w-1:0] offset;
        } fields;
    } cache_addr_t;

    typedef enum logic {
        ready   = 1'b0,
        replace = 1'b1
    } cache_state_t;

    // line number of an address, set above way
    function automatic logic [line_idx_w-1:0] line_of(input cache_addr_t addr);
        return {addr.fields.set_idx, addr.fields.way_idx};
    endfunction

endpackage

`default_nettype wire

// ==== logic/cache_tags.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_tags (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire cache_pkg::cache_addr_t lookup_addr,
    input  wire                         tag_wr_en,
    input  wire cache_pkg::cache_addr_t upd_addr,
    output logic                        hit
);
    import cache_pkg::*;

    localparam int num_lines = 2 ** line_idx_w;

    // one tag and one valid bit per line
    logic [tag_w-1:0]     tag_mem [num_lines];
    logic [num_lines-1:0] valid;

    logic [line_idx_w-1:0] lookup_line;
    logic [line_idx_w-1:0] upd_line;
    logic                  tag_match;

    assign lookup_line = line_of(lookup_addr);
    assign upd_line    = line_of(upd_addr);

    ////////////////////
    // lookup
    ////////////////////

    // purely combinational, the controller decides in the request cycle
    assign tag_match = (tag_mem[lookup_line] == lookup_addr.fields.tag);
    assign hit       = valid[lookup_line] && tag_match;

    ////////////////////
    // update
    ////////////////////

    // new tag is written in the cycle that takes the last refill word
    always_ff @(posedge clk) begin
        if (tag_wr_en) begin
            tag_mem[upd_line] <= upd_addr.fields.tag;
        end
    end

    // all lines start out empty
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid <= '0;
        end else if (tag_wr_en) begin
            valid[upd_line] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_data.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_data (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire                             rd_en,
    input  wire cache_pkg::cache_addr_t     rd_addr,
    input  wire                             cpu_wr_en,
    input  wire [3:0]                       wstb,
    input  wire [cache_pkg::addr_w-1:0]     wr_data,
    input  wire                             fill_wr_en,
    input  wire cache_pkg::cache_addr_t     fill_addr,
    input  wire [cache_pkg::word_idx_w-1:0] fill_word_idx,
    input  wire [cache_pkg::addr_w-1:0]     fill_data,
    output logic [cache_pkg::addr_w-1:0]    rd_data
);
    import cache_pkg::*;

    localparam int lanes     = 4;
    localparam int num_words = (2 ** line_idx_w) * words_per_line;
    localparam int wsel_w    = line_idx_w + word_idx_w;

    // four byte lanes, lane 0 holds the lowest address of each word
    logic [7:0] lane_mem [lanes][num_words];

    logic [word_idx_w-1:0] cpu_word;
    logic [wsel_w-1:0]     cpu_wsel;
    logic [wsel_w-1:0]     fill_wsel;

    // word inside the line comes from the upper offset bits
    assign cpu_word  = rd_addr.fields.offset[offset_w-1 -: word_idx_w];
    assign cpu_wsel  = {line_of(rd_addr), cpu_word};
    assign fill_wsel = {line_of(fill_addr), fill_word_idx};

    ////////////////////
    // writes
    ////////////////////

    // refill and cpu writes never overlap, refill only runs while miss is high
    always_ff @(posedge clk) begin
        if (fill_wr_en) begin
            for (int lane = 0; lane < lanes; lane++) begin
                lane_mem[lane][fill_wsel] <= fill_data[lane*8 +: 8];
            end
        end else if (cpu_wr_en) begin
            for (int lane = 0; lane < lanes; lane++) begin
                if (wstb[lane]) begin
                    lane_mem[lane][cpu_wsel] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // read
    ////////////////////

    // the word is held until the next read hit
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            for (int lane = 0; lane < lanes; lane++) begin
                rd_data[lane*8 +: 8] <= lane_mem[lane][cpu_wsel];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_fill_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_fill_ctrl (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire cache_pkg::cache_addr_t      cpu_addr,
    input  wire                              cpu_re,
    input  wire                              cpu_we,
    input  wire                              hit,
    input  wire                              mem_data_valid,
    input  wire                              mem_last,
    output logic                             rd_en,
    output logic                             cpu_wr_en,
    output logic                             fill_wr_en,
    output cache_pkg::cache_addr_t           fill_addr,
    output logic [cache_pkg::word_idx_w-1:0] fill_word_idx,
    output logic                             tag_wr_en,
    output logic [cache_pkg::addr_w-1:0]     mem_addr,
    output logic                             miss
);
    import cache_pkg::*;

    cache_state_t          state;
    cache_addr_t           miss_addr;
    logic [word_idx_w-1:0] word_cnt;
    logic [addr_w-1:0]     line_base;
    logic                  req;
    logic                  in_ready;
    logic                  start_fill;

    assign req        = cpu_re || cpu_we;
    assign in_ready   = (state == ready);
    assign start_fill = in_ready && req && !hit;

    ////////////////////
    // hit path
    ////////////////////

    assign rd_en     = in_ready && cpu_re && hit;
    assign cpu_wr_en = in_ready && cpu_we && hit;

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= ready;
            word_cnt <= '0;
        end else begin
            case (state)
                ready: begin
                    if (start_fill) begin
                        state    <= replace;
                        word_cnt <= '0;
                    end
                end
                replace: begin
                    // one word per valid strobe, mem_last closes the line
                    if (mem_data_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (mem_last) begin
                            state <= ready;
                        end
                    end
                end
                default: state <= ready;
            endcase
        end
    end

    // address of the missing request, held for the whole refill
    always_ff @(posedge clk) begin
        if (start_fill) begin
            miss_addr <= cpu_addr;
        end
    end

    ////////////////////
    // refill outputs
    ////////////////////

    assign miss          = (state == replace);
    assign fill_wr_en    = miss && mem_data_valid;
    assign tag_wr_en     = fill_wr_en && mem_last;
    assign fill_addr     = miss_addr;
    assign fill_word_idx = word_cnt;

    // line-aligned base, then step one word per counted strobe
    assign line_base = {miss_addr.raw[addr_w-1:offset_w], {offset_w{1'b0}}};
    assign mem_addr  = miss ? line_base + addr_w'({word_cnt, 2'b00}) : '0;

endmodule

`default_nettype wire

// ==== logic/cache_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_top (
    input  wire                          clk,
    input  wire                          reset_n,

    // cpu side
    input  wire cache_pkg::cache_addr_t  cpu_addr,
    input  wire [cache_pkg::addr_w-1:0]  cpu_data_in,
    input  wire                          cpu_we,
    input  wire                          cpu_re,
    input  wire [3:0]                    cpu_wstb,
    output wire [cache_pkg::addr_w-1:0]  cpu_data_out,
    output wire                          miss,

    // memory side
    input  wire [cache_pkg::addr_w-1:0]  mem_data_in,
    input  wire                          mem_data_valid,
    input  wire                          mem_last,
    output wire [cache_pkg::addr_w-1:0]  mem_addr
);
    import cache_pkg::*;

    wire                  hit;
    wire                  rd_en;
    wire                  cpu_wr_en;
    wire                  fill_wr_en;
    wire                  tag_wr_en;
    cache_addr_t          fill_addr;
    wire [word_idx_w-1:0] fill_word_idx;

    ////////////////////
    // tag store
    ////////////////////

    cache_tags u_tags (
        .clk         (clk),
        .reset_n     (reset_n),
        .lookup_addr (cpu_addr),
        .tag_wr_en   (tag_wr_en),
        .upd_addr    (fill_addr),
        .hit         (hit)
    );

    ////////////////////
    // data store
    ////////////////////

    cache_data u_data (
        .clk           (clk),
        .reset_n       (reset_n),
        .rd_en         (rd_en),
        .rd_addr       (cpu_addr),
        .cpu_wr_en     (cpu_wr_en),
        .wstb          (cpu_wstb),
        .wr_data       (cpu_data_in),
        .fill_wr_en    (fill_wr_en),
        .fill_addr     (fill_addr),
        .fill_word_idx (fill_word_idx),
        .fill_data     (mem_data_in),
        .rd_data       (cpu_data_out)
    );

    ////////////////////
    // refill control
    ////////////////////

    cache_fill_ctrl u_fill_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_addr       (cpu_addr),
        .cpu_re         (cpu_re),
        .cpu_we         (cpu_we),
        .hit            (hit),
        .mem_data_valid (mem_data_valid),
        .mem_last       (mem_last),
        .rd_en          (rd_en),
        .cpu_wr_en      (cpu_wr_en),
        .fill_wr_en     (fill_wr_en),
        .fill_addr      (fill_addr),
        .fill_word_idx  (fill_word_idx),
        .tag_wr_en      (tag_wr_en),
        .mem_addr       (mem_addr),
        .miss           (miss)
    );

endmodule

`default_nettype wire

// ==== verif/cache_top_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_top_chk (
    input wire                          clk,
    input wire                          reset_n,
    input wire                          miss,
    input wire                          mem_data_valid,
    input wire                          mem_last,
    input wire cache_pkg::cache_state_t state
);
    import cache_pkg::*;

    // a refill only ends with the last memory word, or by reset
    miss_ends_on_last: assert property (
        @(posedge clk) disable iff (!reset_n)
            $fell(miss) |-> $past(mem_data_valid && mem_last) || !$past(reset_n)
    ) else $error("miss fell without mem_last");

    // the memory only answers during a refill
    no_valid_in_ready: assert property (
        @(posedge clk) disable iff (!reset_n) mem_data_valid |-> state == replace
    ) else $error("mem_data_valid seen while the cache is ready");

    miss_low_after_reset: assert property (
        @(posedge clk) !reset_n |=> !miss
    ) else $error("miss is high in the cycle after reset");

endmodule

bind cache_top cache_top_chk chk (
    .clk            (clk),
    .reset_n        (reset_n),
    .miss           (miss),
    .mem_data_valid (mem_data_valid),
    .mem_last       (mem_last),
    .state          (u_fill_ctrl.state)
);

`default_nettype wire

// ==== verif/cache_top_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_top_tb;
    localparam logic [31:0] mem_pattern    = 32'h5a5a_0000;
    localparam int          refill_cycles  = 2 * 32 + 4;
    localparam int          num_refills    = 5;
    localparam int          timeout_cycles = 3 * num_refills * refill_cycles;

    logic        clk;
    logic        reset_n;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_data_in;
    logic        cpu_we;
    logic        cpu_re;
    logic [3:0]  cpu_wstb;
    wire  [31:0] cpu_data_out;
    wire         miss;
    logic [31:0] mem_data_in;
    logic        mem_data_valid;
    logic        mem_last;
    wire  [31:0] mem_addr;

    int          error_count;
    int          cycle_count;
    int          words_sent;
    logic [31:0] lcg_state;
    logic [31:0] line_a;
    logic [31:0] fill_log [$];
    logic [7:0]  written [logic [31:0]];

    cache_top uut (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_addr       (cpu_addr),
        .cpu_data_in    (cpu_data_in),
        .cpu_we         (cpu_we),
        .cpu_re         (cpu_re),
        .cpu_wstb       (cpu_wstb),
        .cpu_data_out   (cpu_data_out),
        .miss           (miss),
        .mem_data_in    (mem_data_in),
        .mem_data_valid (mem_data_valid),
        .mem_last       (mem_last),
        .mem_addr       (mem_addr)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // memory model
    ////////////////////

    // one word every second cycle while miss is high, mem_last on the 32nd
    always @(posedge clk) begin
        #1;
        if (!reset_n || !miss) begin
            mem_data_valid = 1'b0;
            mem_last       = 1'b0;
            words_sent     = 0;
        end else if (mem_data_valid) begin
            mem_data_valid = 1'b0;
            mem_last       = 1'b0;
            words_sent     = words_sent + 1;
        end else begin
            mem_data_valid = 1'b1;
            mem_data_in    = mem_addr ^ mem_pattern;
            mem_last       = (words_sent == 31);
            fill_log.push_back(mem_addr);
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] line_base(input logic [31:0] addr);
        return {addr[31:7], 7'b0};
    endfunction

    // memory pattern with the bytes the cpu wrote since the last refill on top
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        logic [31:0] value;
        word_addr = {addr[31:2], 2'b00};
        value     = word_addr ^ mem_pattern;
        for (int lane = 0; lane < 4; lane++) begin
            if (written.exists(word_addr + 32'(lane))) begin
                value[lane*8 +: 8] = written[word_addr + 32'(lane)];
            end
        end
        return value;
    endfunction

    task automatic forget_line(input logic [31:0] addr);
        for (int b = 0; b < 128; b++) begin
            written.delete(line_base(addr) + 32'(b));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            error_count++;
            $display("error: %s", what);
        end
    endtask

    // all cpu tasks start and end 1 ns after a rising edge
    task automatic read_word(input logic [31:0] addr);
        cpu_addr = addr;
        cpu_re   = 1'b1;
        @(posedge clk);
        #1;
        cpu_re = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] stb);
        cpu_addr    = addr;
        cpu_data_in = data;
        cpu_wstb    = stb;
        cpu_we      = 1'b1;
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
    endtask

    task automatic wait_refill();
        while (miss) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        cpu_re  = 1'b0;
        cpu_we  = 1'b0;
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
    endtask

    // read that must miss, then the whole line must come in address order
    task automatic miss_and_refill(input string name, input logic [31:0] addr);
        fill_log.delete();
        read_word(addr);
        check_true(miss, {name, ": read did not raise miss"});
        wait_refill();
        check_word({name, " word count"}, 32, 32'(fill_log.size()));
        for (int i = 0; i < fill_log.size(); i++) begin
            check_word({name, " mem_addr"}, line_base(addr) + 32'(4 * i), fill_log[i]);
        end
        forget_line(addr);
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_cold_read_miss();
        line_a = next_rand() & 32'hffff_fffc;
        miss_and_refill("cold_read_miss", line_a);
    endtask

    task automatic test_read_hit();
        logic [31:0] addr;
        for (int i = 0; i < 32; i++) begin
            addr = line_base(line_a) + 32'(4 * i);
            read_word(addr);
            check_true(!miss, "read_hit: miss raised on a refilled line");
            check_word("read_hit", expected_word(addr), cpu_data_out);
        end
    endtask

    task automatic test_write_strobe();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  stb;
        repeat (4) begin
            r    = next_rand();
            addr = line_base(line_a) + {25'd0, r[6:2], 2'b00};
            data = next_rand();
            stb  = r[11:8];
            write_word(addr, data, stb);
            check_true(!miss, "write_strobe: write hit raised miss");
            for (int lane = 0; lane < 4; lane++) begin
                if (stb[lane]) begin
                    written[addr + 32'(lane)] = data[lane*8 +: 8];
                end
            end
            read_word(addr);
            check_word("write_strobe", expected_word(addr), cpu_data_out);
        end
    endtask

    task automatic test_conflict();
        logic [31:0] line_b;
        logic [31:0] addr;
        // other tag, same set and way
        line_b = line_a ^ 32'h0001_8000;
        miss_and_refill("conflict_b", line_b);
        addr = line_base(line_b) + 32'h44;
        read_word(addr);
        check_word("conflict_b", expected_word(addr), cpu_data_out);
        miss_and_refill("conflict_a", line_a);
        read_word(line_a);
        check_word("conflict_a", line_a ^ mem_pattern, cpu_data_out);
    endtask

    task automatic test_reset_valid();
        logic [31:0] other;
        read_word(line_a);
        check_true(!miss, "reset_valid: line missed before reset");
        // refill of another tag, cut short by reset after two words
        other = line_a ^ 32'h0002_0000;
        read_word(other);
        check_true(miss, "reset_valid: other tag did not raise miss");
        repeat (3) @(posedge clk);
        #1;
        apply_reset();
        check_true(!miss, "reset_valid: miss high after reset");
        check_word("reset_valid data", 32'h0, cpu_data_out);
        check_word("reset_valid mem_addr", 32'h0, mem_addr);
        miss_and_refill("reset_valid", line_a);
        read_word(line_a);
        check_word("reset_valid", expected_word(line_a), cpu_data_out);
    endtask

    initial begin
        clk            = 1'b0;
        reset_n        = 1'b0;
        cpu_addr       = '0;
        cpu_data_in    = '0;
        cpu_we         = 1'b0;
        cpu_re         = 1'b0;
        cpu_wstb       = '0;
        mem_data_in    = '0;
        mem_data_valid = 1'b0;
        mem_last       = 1'b0;
        error_count    = 0;
        cycle_count    = 0;
        words_sent     = 0;
        lcg_state      = 32'hf8a2;
        apply_reset();
        test_cold_read_miss();
        test_read_hit();
        test_write_strobe();
        test_conflict();
        test_reset_valid();
        $display("checks done, %0d errors", error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cache_top.f ====
logic/cache_pkg.sv
logic/cache_tags.sv
logic/cache_data.sv
logic/cache_fill_ctrl.sv
logic/cache_top.sv
verif/cache_top_chk.sv
verif/cache_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module cache_top_tb \
    -f cache_top.f \
    -o sim_cache_top

# a crash or a stop from a bound assertion also counts as a failure
./obj_dir/sim_cache_top > sim.log 2>&1 || echo "CHECKS FAILED" >> sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
